// ==== rv_branch_unit.sv ====
`default_nettype none

module rv_branch_unit #(
    parameter int WIDTH = rv_exec_pkg::XLEN
) (
    input  wire rv_exec_pkg::exec_op_t i_op,
    input  wire logic [WIDTH-1:0]      i_a,
    input  wire logic [WIDTH-1:0]      i_b,
    input  wire logic [31:0]           i_ir,
    input  wire logic [WIDTH-1:0]      i_pc,
    output logic                       o_taken,
    output logic [WIDTH-1:0]           o_target,
    output logic [WIDTH-1:0]           o_link,
    output logic                       o_writes_link
);
    import rv_exec_pkg::*;

    logic [WIDTH-1:0] off_b;
    logic [WIDTH-1:0] off_j;
    logic [WIDTH-1:0] off_i;
    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             cond;
    logic             is_jump;

    // Scattered immediate fields, bit 0 implied zero for B and J
    assign off_b = WIDTH'($signed({i_ir[31], i_ir[7], i_ir[30:25], i_ir[11:8], 1'b0}));
    assign off_j = WIDTH'($signed({i_ir[31], i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0}));
    assign off_i = WIDTH'($signed(i_ir[31:20]));

    assign eq   = (i_a == i_b);
    assign lt_s = $signed(i_a) < $signed(i_b);
    assign lt_u = i_a < i_b;

    always_comb begin
        case (i_op)
            OP_BEQ:  cond = eq;
            OP_BNE:  cond = !eq;
            OP_BLT:  cond = lt_s;
            OP_BGE:  cond = !lt_s;
            OP_BLTU: cond = lt_u;
            OP_BGEU: cond = !lt_u;
            default: cond = 1'b0;
        endcase
    end

    assign is_jump = (i_op == OP_JAL) || (i_op == OP_JALR);

    assign o_taken = (is_branch_op(i_op) && cond) || is_jump;

    always_comb begin
        if (i_op == OP_JALR) begin
            o_target = i_a + off_i;         // Register relative, LSB kept
        end else if (i_op == OP_JAL) begin
            o_target = i_pc + off_j;
        end else begin
            o_target = i_pc + off_b;
        end
    end

    assign o_link        = i_pc + WIDTH'(4);
    assign o_writes_link = is_jump;

endmodule

`default_nettype wire

// ==== rv_divider.sv ====
`default_nettype none

module rv_divider #(
    parameter int WIDTH = rv_exec_pkg::XLEN
) (
    input  wire logic             i_clk,
    input  wire logic             i_rst_n,
    input  wire logic             i_start,
    input  wire logic             i_signed,
    input  wire logic [WIDTH-1:0] i_dividend,
    input  wire logic [WIDTH-1:0] i_divisor,
    output logic [WIDTH-1:0]      o_quotient,
    output logic [WIDTH-1:0]      o_remainder,
    output logic                  o_done
);

    localparam int CNT_W = $clog2(WIDTH);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_FINAL
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] count_q;

    logic [WIDTH-1:0] rem_q;        // Partial remainder
    logic [WIDTH-1:0] quo_q;        // Dividend shifts out, quotient shifts in
    logic [WIDTH-1:0] dvs_q;
    logic             q_neg_q;
    logic             r_neg_q;
    logic             zero_q;

    logic             a_neg;
    logic             b_neg;
    logic [WIDTH-1:0] a_mag;
    logic [WIDTH-1:0] b_mag;
    logic [WIDTH:0]   trial;
    logic [WIDTH:0]   diff;
    logic             fits;

    // Setup happens in the start cycle, magnitudes go straight into the regs
    assign a_neg = i_signed & i_dividend[WIDTH-1];
    assign b_neg = i_signed & i_divisor[WIDTH-1];
    assign a_mag = a_neg ? -i_dividend : i_dividend;
    assign b_mag = b_neg ? -i_divisor : i_divisor;

    assign trial = {rem_q, quo_q[WIDTH-1]};
    assign diff  = trial - {1'b0, dvs_q};
    assign fits  = ~diff[WIDTH];                    // No borrow

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= S_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (i_start) begin
                        state_q <= S_RUN;
                        count_q <= '0;
                    end
                end
                S_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == CNT_W'(WIDTH - 1)) begin
                        state_q <= S_FINAL;
                    end
                end
                default: state_q <= S_IDLE;     // Final cycle, back to idle
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state_q == S_IDLE && i_start) begin
            rem_q   <= '0;
            quo_q   <= a_mag;
            dvs_q   <= b_mag;
            q_neg_q <= a_neg ^ b_neg;
            r_neg_q <= a_neg;
            zero_q  <= (i_divisor == '0);
        end else if (state_q == S_RUN) begin
            rem_q <= fits ? diff[WIDTH-1:0] : trial[WIDTH-1:0];
            quo_q <= {quo_q[WIDTH-2:0], fits};
        end
    end

    // Divide by zero leaves |dividend| in rem_q, so only the quotient needs forcing.
    // Most negative by -1 already yields the dividend and zero.
    assign o_quotient  = zero_q ? '1 : (q_neg_q ? -quo_q : quo_q);
    assign o_remainder = r_neg_q ? -rem_q : rem_q;
    assign o_done      = (state_q == S_FINAL);

    a_start_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> state_q == S_IDLE)
        else $error("divider restarted while a division is in progress");

    a_done_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_start |-> ##(WIDTH + 1) o_done)
        else $error("divider done pulse missed its slot");

endmodule

`default_nettype wire

// ==== rv_exec_pkg.sv ====
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN = 32;

    // Issue to write strobe for DIV/DIVU/REM/REMU
    localparam int DIV_LATENCY = XLEN + 2;

    // Numbering follows the decoder, 45..63 are unused
    typedef enum logic [5:0] {
        OP_ADD    = 6'd0,
        OP_SUB    = 6'd1,
        OP_SLL    = 6'd2,
        OP_SLT    = 6'd3,
        OP_SLTU   = 6'd4,
        OP_XOR    = 6'd5,
        OP_SRL    = 6'd6,
        OP_SRA    = 6'd7,
        OP_OR     = 6'd8,
        OP_AND    = 6'd9,
        OP_MUL    = 6'd10,
        OP_MULH   = 6'd11,
        OP_MULHS  = 6'd12,          // Signed times unsigned, high word
        OP_MULHU  = 6'd13,
        OP_DIV    = 6'd14,
        OP_DIVU   = 6'd15,
        OP_REM    = 6'd16,
        OP_REMU   = 6'd17,
        OP_ADDI   = 6'd18,
        OP_SLTI   = 6'd19,
        OP_SLTIU  = 6'd20,
        OP_XORI   = 6'd21,
        OP_ORI    = 6'd22,
        OP_ANDI   = 6'd23,
        OP_SLLI   = 6'd24,
        OP_SRLI   = 6'd25,
        OP_SRAI   = 6'd26,
        OP_LB     = 6'd27,          // Loads and stores pass through silently
        OP_LH     = 6'd28,
        OP_LW     = 6'd29,
        OP_LBU    = 6'd30,
        OP_LHU    = 6'd31,
        OP_SB     = 6'd32,
        OP_SH     = 6'd33,
        OP_SW     = 6'd34,
        OP_BEQ    = 6'd35,
        OP_BNE    = 6'd36,
        OP_BLT    = 6'd37,
        OP_BGE    = 6'd38,
        OP_BLTU   = 6'd39,
        OP_BGEU   = 6'd40,
        OP_JAL    = 6'd41,
        OP_JALR   = 6'd42,
        OP_LUI    = 6'd43,
        OP_AUIPC  = 6'd44
    } exec_op_t;

    function automatic logic is_div_op(input exec_op_t op);
        return op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    endfunction

    function automatic logic is_branch_op(input exec_op_t op);
        return op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    endfunction

endpackage

`default_nettype wire

// ==== rv_exec_unit.sv ====
`default_nettype none

module rv_exec_unit #(
    parameter int WIDTH = rv_exec_pkg::XLEN
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_issue,
    input  wire rv_exec_pkg::exec_op_t i_op,
    input  wire logic [WIDTH-1:0]      i_a,
    input  wire logic [WIDTH-1:0]      i_b,
    input  wire logic [31:0]           i_ir,
    input  wire logic [WIDTH-1:0]      i_pc,
    output logic [WIDTH-1:0]           o_result,
    output logic                       o_load_regfile,
    output logic [WIDTH-1:0]           o_jump_address,
    output logic                       o_jump_valid,
    output logic                       o_busy
);
    import rv_exec_pkg::*;

    logic [WIDTH-1:0] alu_result;
    logic             alu_writes;
    logic             br_taken;
    logic [WIDTH-1:0] br_target;
    logic [WIDTH-1:0] br_link;
    logic             link_writes;
    logic [WIDTH-1:0] div_quotient;
    logic [WIDTH-1:0] div_remainder;
    logic             div_done;

    logic             issue_ok;
    logic             div_start;
    logic             div_signed;
    logic             sel_rem_q;

    assign issue_ok   = i_issue && !o_busy;         // Issue during a divide is dropped
    assign div_start  = issue_ok && is_div_op(i_op);
    assign div_signed = (i_op == OP_DIV) || (i_op == OP_REM);

    rv_int_alu #(
        .WIDTH (WIDTH)
    ) alu_i (
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .i_ir     (i_ir),
        .i_pc     (i_pc),
        .o_result (alu_result),
        .o_writes (alu_writes)
    );

    rv_branch_unit #(
        .WIDTH (WIDTH)
    ) branch_i (
        .i_op          (i_op),
        .i_a           (i_a),
        .i_b           (i_b),
        .i_ir          (i_ir),
        .i_pc          (i_pc),
        .o_taken       (br_taken),
        .o_target      (br_target),
        .o_link        (br_link),
        .o_writes_link (link_writes)
    );

    rv_divider #(
        .WIDTH (WIDTH)
    ) divider_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (div_start),
        .i_signed    (div_signed),
        .i_dividend  (i_a),
        .i_divisor   (i_b),
        .o_quotient  (div_quotient),
        .o_remainder (div_remainder),
        .o_done      (div_done)
    );

    always_ff @(posedge i_clk) begin
        if (div_start) begin
            sel_rem_q <= (i_op == OP_REM) || (i_op == OP_REMU);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result       <= '0;
            o_load_regfile <= 1'b0;
            o_jump_address <= '0;
            o_jump_valid   <= 1'b0;
            o_busy         <= 1'b0;
        end else begin
            o_load_regfile <= 1'b0;                 // Strobes last one cycle
            o_jump_valid   <= 1'b0;
            if (div_done) begin
                o_result       <= sel_rem_q ? div_remainder : div_quotient;
                o_load_regfile <= 1'b1;
                o_busy         <= 1'b0;
            end
            if (div_start) begin
                o_busy <= 1'b1;
            end
            if (issue_ok && (alu_writes || link_writes)) begin
                o_result       <= link_writes ? br_link : alu_result;
                o_load_regfile <= 1'b1;
            end
            if (issue_ok && br_taken) begin
                o_jump_address <= br_target;
                o_jump_valid   <= 1'b1;
            end
        end
    end

    a_no_issue_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_issue |-> !o_busy)
        else $error("issue arrived while a divide was in progress");

    a_div_no_jump: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        div_done |=> !o_jump_valid)
        else $error("divide write coincided with a jump strobe");

endmodule

`default_nettype wire

// ==== rv_int_alu.sv ====
`default_nettype none

module rv_int_alu #(
    parameter int WIDTH = rv_exec_pkg::XLEN
) (
    input  wire rv_exec_pkg::exec_op_t i_op,
    input  wire logic [WIDTH-1:0]      i_a,
    input  wire logic [WIDTH-1:0]      i_b,
    input  wire logic [31:0]           i_ir,
    input  wire logic [WIDTH-1:0]      i_pc,
    output logic [WIDTH-1:0]           o_result,
    output logic                       o_writes
);
    import rv_exec_pkg::*;

    localparam int SHAMT_W = $clog2(WIDTH);

    logic [WIDTH-1:0]   imm_i;
    logic [WIDTH-1:0]   imm_u;
    logic [SHAMT_W-1:0] shamt_r;
    logic [SHAMT_W-1:0] shamt_i;
    logic               lt_reg_s;
    logic               lt_reg_u;
    logic               lt_imm_s;
    logic               lt_imm_u;

    logic signed [2*WIDTH-1:0] prod_ss;
    logic [2*WIDTH-1:0]        prod_su;
    logic [2*WIDTH-1:0]        prod_uu;

    assign imm_i   = WIDTH'($signed(i_ir[31:20]));          // I-type, sign extended
    assign imm_u   = WIDTH'($signed({i_ir[31:12], 12'b0})); // U-type upper immediate
    assign shamt_r = i_b[SHAMT_W-1:0];
    assign shamt_i = imm_i[SHAMT_W-1:0];

    assign lt_reg_s = $signed(i_a) < $signed(i_b);
    assign lt_reg_u = i_a < i_b;
    assign lt_imm_s = $signed(i_a) < $signed(imm_i);
    assign lt_imm_u = i_a < imm_i;

    // Full double-width products, high or low word picked below
    assign prod_ss = $signed(i_a) * $signed(i_b);
    assign prod_su = {{WIDTH{i_a[WIDTH-1]}}, i_a} * {{WIDTH{1'b0}}, i_b};
    assign prod_uu = i_a * i_b;

    always_comb begin
        o_result = '0;
        o_writes = 1'b1;
        case (i_op)
            OP_ADD:   o_result = i_a + i_b;
            OP_SUB:   o_result = i_a - i_b;
            OP_SLL:   o_result = i_a << shamt_r;
            OP_SLT:   o_result = WIDTH'(lt_reg_s);
            OP_SLTU:  o_result = WIDTH'(lt_reg_u);
            OP_XOR:   o_result = i_a ^ i_b;
            OP_SRL:   o_result = i_a >> shamt_r;
            OP_SRA:   o_result = $signed(i_a) >>> shamt_r;
            OP_OR:    o_result = i_a | i_b;
            OP_AND:   o_result = i_a & i_b;
            OP_MUL:   o_result = prod_ss[WIDTH-1:0];
            OP_MULH:  o_result = prod_ss[2*WIDTH-1:WIDTH];
            OP_MULHS: o_result = prod_su[2*WIDTH-1:WIDTH];
            OP_MULHU: o_result = prod_uu[2*WIDTH-1:WIDTH];
            OP_ADDI:  o_result = i_a + imm_i;
            OP_SLTI:  o_result = WIDTH'(lt_imm_s);
            OP_SLTIU: o_result = WIDTH'(lt_imm_u);
            OP_XORI:  o_result = i_a ^ imm_i;
            OP_ORI:   o_result = i_a | imm_i;
            OP_ANDI:  o_result = i_a & imm_i;
            OP_SLLI:  o_result = i_a << shamt_i;
            OP_SRLI:  o_result = i_a >> shamt_i;
            OP_SRAI:  o_result = $signed(i_a) >>> shamt_i;
            OP_LUI:   o_result = imm_u;
            OP_AUIPC: o_result = i_pc + imm_u;
            default: begin
                // Divides, branches, jumps, memory ops and unused codes
                o_writes = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== tb_rv_exec.sv ====
`default_nettype none

module tb_rv_exec;
    import rv_exec_pkg::*;

    localparam int          N_VEC  = 38;
    localparam int          N_RAND = 24;
    localparam logic [31:0] PC0    = 32'h0000_1000;
    localparam int          LIMIT  = (N_VEC + N_RAND) * (DIV_LATENCY + 4) * 8 + 20 * 8;

    typedef struct packed {
        exec_op_t    op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ir;
        logic [31:0] pc;
        logic [31:0] res;
        logic        wr;
        logic        jmp;
        logic [31:0] tgt;
    } vec_t;

    logic        i_clk;
    logic        i_rst_n;
    logic        i_issue;
    exec_op_t    i_op;
    logic [31:0] i_a;
    logic [31:0] i_b;
    logic [31:0] i_ir;
    logic [31:0] i_pc;
    logic [31:0] o_result;
    logic        o_load_regfile;
    logic [31:0] o_jump_address;
    logic        o_jump_valid;
    logic        o_busy;

    vec_t        vec_tab [0:N_VEC-1];
    int          n_vec;
    logic [31:0] last_res;          // Held values between strobes
    logic [31:0] last_tgt;

    rv_exec_unit #(
        .WIDTH (32)
    ) dut_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_issue        (i_issue),
        .i_op           (i_op),
        .i_a            (i_a),
        .i_b            (i_b),
        .i_ir           (i_ir),
        .i_pc           (i_pc),
        .o_result       (o_result),
        .o_load_regfile (o_load_regfile),
        .o_jump_address (o_jump_address),
        .o_jump_valid   (o_jump_valid),
        .o_busy         (o_busy)
    );

    always #4 i_clk = ~i_clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_vec(input exec_op_t op, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] ir, input logic [31:0] pc,
                           input logic [31:0] res, input logic wr, input logic jmp,
                           input logic [31:0] tgt);
        vec_tab[n_vec] = '{op, a, b, ir, pc, res, wr, jmp, tgt};
        n_vec++;
    endtask

    // RISC-V M extension division rules
    function automatic logic [31:0] div_model(input exec_op_t op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] q;
        logic [31:0] r;
        logic        sgn;
        sgn = (op == OP_DIV) || (op == OP_REM);
        if (b == 32'h0) begin
            q = 32'hffff_ffff;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            q = a;
            r = 32'h0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);    // Truncates toward zero
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return (op == OP_REM || op == OP_REMU) ? r : q;
    endfunction

    task automatic apply(input vec_t v);
        int cycles;
        @(posedge i_clk);
        i_issue <= 1'b1;
        i_op    <= v.op;
        i_a     <= v.a;
        i_b     <= v.b;
        i_ir    <= v.ir;
        i_pc    <= v.pc;
        @(posedge i_clk);
        i_issue <= 1'b0;
        @(negedge i_clk);
        cycles = 1;
        if (v.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) begin
            while (!o_load_regfile && cycles < DIV_LATENCY + 4) begin
                check_value(o_busy, 1'b1, "busy during divide");
                @(negedge i_clk);
                cycles++;
            end
            check_value(cycles, DIV_LATENCY, "divide latency");
        end
        check_value(o_load_regfile, v.wr, "write strobe");
        check_value(o_jump_valid, v.jmp, "jump strobe");
        check_value(o_busy, 1'b0, "busy after completion");
        if (v.wr) last_res = v.res;
        if (v.jmp) last_tgt = v.tgt;
        check_value(o_result, last_res, "result");
        check_value(o_jump_address, last_tgt, "jump address");
        @(negedge i_clk);
        check_value(o_load_regfile, 1'b0, "write strobe width");
        check_value(o_jump_valid, 1'b0, "jump strobe width");
    endtask

    initial begin
        #(LIMIT);
        $display("Watchdog timeout: the tests did not finish in the expected time");
        $display("TESTS FAILED");
        $fatal(1);
    end

    initial begin
        exec_op_t    div_ops [4];
        vec_t        rv;
        int unsigned sel;
        i_clk    = 1'b0;
        i_rst_n  = 1'b0;
        i_issue  = 1'b0;
        i_op     = OP_ADD;
        i_a      = '0;
        i_b      = '0;
        i_ir     = '0;
        i_pc     = '0;
        n_vec    = 0;
        last_res = '0;
        last_tgt = '0;
        void'($urandom(32'h39ef_2473));
        div_ops  = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU};

        add_vec(OP_ADD,   32'h0000_0007, 32'hffff_fffd, 32'h0, PC0, 32'h0000_0004, 1, 0, 0);
        add_vec(OP_SUB,   32'h0000_0003, 32'h0000_0005, 32'h0, PC0, 32'hffff_fffe, 1, 0, 0);
        add_vec(OP_SLL,   32'h0000_0001, 32'h0000_0023, 32'h0, PC0, 32'h0000_0008, 1, 0, 0);
        add_vec(OP_SRL,   32'h8000_0000, 32'h0000_0004, 32'h0, PC0, 32'h0800_0000, 1, 0, 0);
        add_vec(OP_SRA,   32'h8000_0000, 32'h0000_0004, 32'h0, PC0, 32'hf800_0000, 1, 0, 0);
        add_vec(OP_SLT,   32'hffff_ffff, 32'h0000_0001, 32'h0, PC0, 32'h0000_0001, 1, 0, 0);
        add_vec(OP_SLTU,  32'hffff_ffff, 32'h0000_0001, 32'h0, PC0, 32'h0000_0000, 1, 0, 0);
        add_vec(OP_ADDI,  32'h0000_000a, 32'h0, 32'hffb0_0013, PC0, 32'h0000_0005, 1, 0, 0);
        add_vec(OP_SLTI,  32'hffff_fffe, 32'h0, 32'hfff0_0013, PC0, 32'h0000_0001, 1, 0, 0);
        add_vec(OP_SLTIU, 32'h0000_0005, 32'h0, 32'hfff0_0013, PC0, 32'h0000_0001, 1, 0, 0);
        add_vec(OP_XORI,  32'h0000_0f0f, 32'h0, 32'h0ff0_0013, PC0, 32'h0000_0ff0, 1, 0, 0);
        add_vec(OP_SRAI,  32'h8000_0000, 32'h0, 32'h4040_0013, PC0, 32'hf800_0000, 1, 0, 0);
        add_vec(OP_LUI,   32'h0, 32'h0, 32'h1234_5037, PC0, 32'h1234_5000, 1, 0, 0);
        add_vec(OP_AUIPC, 32'h0, 32'h0, 32'h0000_2017, PC0, 32'h0000_3000, 1, 0, 0);
        add_vec(OP_MUL,   32'hffff_ffff, 32'hffff_ffff, 32'h0, PC0, 32'h0000_0001, 1, 0, 0);
        add_vec(OP_MULH,  32'h8000_0000, 32'h0000_0002, 32'h0, PC0, 32'hffff_ffff, 1, 0, 0);
        add_vec(OP_MULHS, 32'hffff_ffff, 32'hffff_ffff, 32'h0, PC0, 32'hffff_ffff, 1, 0, 0);
        add_vec(OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'h0, PC0, 32'hffff_fffe, 1, 0, 0);
        add_vec(OP_LW,    32'h0000_1234, 32'h0000_0010, 32'h0, PC0, 32'h0, 0, 0, 0);
        // Branch offsets are +16 (0x863) and -8 (0xfe000ce3)
        add_vec(OP_BEQ,   32'h5, 32'h5, 32'h0000_0863, PC0, 32'h0, 0, 1, 32'h0000_1010);
        add_vec(OP_BNE,   32'h5, 32'h6, 32'hfe00_0ce3, PC0, 32'h0, 0, 1, 32'h0000_0ff8);
        add_vec(OP_BLT,   32'hffff_ffff, 32'h1, 32'h0000_0863, PC0, 32'h0, 0, 1, 32'h0000_1010);
        add_vec(OP_BGE,   32'h1, 32'hffff_ffff, 32'hfe00_0ce3, PC0, 32'h0, 0, 1, 32'h0000_0ff8);
        add_vec(OP_BLTU,  32'h1, 32'hffff_ffff, 32'h0000_0863, PC0, 32'h0, 0, 1, 32'h0000_1010);
        add_vec(OP_BGEU,  32'hffff_ffff, 32'h1, 32'h0000_0863, PC0, 32'h0, 0, 1, 32'h0000_1010);
        add_vec(OP_BEQ,   32'h5, 32'h6, 32'h0000_0863, PC0, 32'h0, 0, 0, 0);
        add_vec(OP_BLT,   32'h1, 32'hffff_ffff, 32'h0000_0863, PC0, 32'h0, 0, 0, 0);
        add_vec(OP_BGEU,  32'h1, 32'hffff_ffff, 32'h0000_0863, PC0, 32'h0, 0, 0, 0);
        add_vec(OP_JAL,   32'h0, 32'h0, 32'h1000_006f, PC0, 32'h0000_1004, 1, 1, 32'h0000_1100);
        add_vec(OP_JALR,  32'h2000, 32'h0, 32'hffc0_0067, PC0, 32'h0000_1004, 1, 1, 32'h1ffc);
        add_vec(OP_DIV,   32'hffff_fff9, 32'h2, 32'h0, PC0, 32'hffff_fffd, 1, 0, 0);
        add_vec(OP_REM,   32'hffff_fff9, 32'h2, 32'h0, PC0, 32'hffff_ffff, 1, 0, 0);
        add_vec(OP_DIVU,  32'h0000_0007, 32'h0, 32'h0, PC0, 32'hffff_ffff, 1, 0, 0);
        add_vec(OP_REMU,  32'h0000_0007, 32'h0, 32'h0, PC0, 32'h0000_0007, 1, 0, 0);
        add_vec(OP_DIV,   32'h8000_0000, 32'hffff_ffff, 32'h0, PC0, 32'h8000_0000, 1, 0, 0);
        add_vec(OP_REM,   32'h8000_0000, 32'hffff_ffff, 32'h0, PC0, 32'h0000_0000, 1, 0, 0);
        add_vec(OP_REM,   32'hffff_fffb, 32'h0, 32'h0, PC0, 32'hffff_fffb, 1, 0, 0);
        add_vec(exec_op_t'(6'd50), 32'h1, 32'h2, 32'h0, PC0, 32'h0, 0, 0, 0);

        repeat (10) @(posedge i_clk);
        check_value(o_load_regfile, 1'b0, "write strobe in reset");
        check_value(o_jump_valid, 1'b0, "jump strobe in reset");
        check_value(o_busy, 1'b0, "busy in reset");
        check_value(o_result, 32'h0, "result in reset");
        check_value(o_jump_address, 32'h0, "jump address in reset");
        i_rst_n <= 1'b1;

        for (int i = 0; i < N_VEC; i++) begin
            apply(vec_tab[i]);
        end

        for (int i = 0; i < N_RAND; i++) begin
            rv     = '0;
            rv.op  = div_ops[$urandom % 4];
            rv.a   = $urandom;
            rv.b   = $urandom;
            sel    = $urandom % 8;
            if (sel == 0) begin
                rv.b = 32'h0;
            end else if (sel == 1) begin
                rv.a = 32'h8000_0000;       // Signed overflow case
                rv.b = 32'hffff_ffff;
            end else if (sel == 2) begin
                rv.b = rv.b >> 24;
            end
            rv.pc  = PC0;
            rv.res = div_model(rv.op, rv.a, rv.b);
            rv.wr  = 1'b1;
            apply(rv);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rv_exec_pkg.sv
rv_int_alu.sv
rv_divider.sv
rv_branch_unit.sv
rv_exec_unit.sv
tb_rv_exec.sv
